// File: Bender.yml
package:
  name: rv_core

sources:
  - files:
      - hw/rv_core_pkg.sv
      - hw/fetch_stage.sv
      - hw/decode_stage.sv
      - hw/execute_stage.sv
      - hw/reg_file.sv
      - hw/hazard_unit.sv
      - hw/rv_core_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/rv_core_tb.sv

// File: files.f
+incdir+include
hw/rv_core_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/reg_file.sv
hw/hazard_unit.sv
hw/rv_core_top.sv
tests/rv_core_tb.sv

// File: hw/decode_stage.sv
module decode_stage (
    input  logic                               sys_clk,
    input  logic                               rst_n,
    input  logic                               fd_valid,
    input  logic [rv_core_pkg::XLEN-1:0]       fd_pc,
    input  logic [rv_core_pkg::XLEN-1:0]       fd_inst,
    input  logic                               flush_de,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rs1,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rs2,
    output logic                               rs1_used,
    output logic                               rs2_used,
    input  logic [rv_core_pkg::XLEN-1:0]       rs1_data,
    input  logic [rv_core_pkg::XLEN-1:0]       rs2_data,
    input  logic [1:0]                         fwd_sel_a,
    input  logic [1:0]                         fwd_sel_b,
    input  logic [rv_core_pkg::XLEN-1:0]       ex_result,
    input  logic [rv_core_pkg::XLEN-1:0]       wb_data,
    output logic                               de_valid,
    output rv_core_pkg::inst_kind_e            de_kind,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] de_rd,
    output logic [rv_core_pkg::XLEN-1:0]       de_op_a,
    output logic [rv_core_pkg::XLEN-1:0]       de_op_b,
    output logic [rv_core_pkg::XLEN-1:0]       de_branch_target,
    output logic [rv_core_pkg::XLEN-1:0]       de_pc
);

    rv_core_pkg::inst_kind_e      kind;
    logic [6:0]                   funct7;
    logic [2:0]                   funct3;
    logic [rv_core_pkg::XLEN-1:0] i_imm;
    logic [rv_core_pkg::XLEN-1:0] u_imm;
    logic [rv_core_pkg::XLEN-1:0] b_imm;
    logic [rv_core_pkg::XLEN-1:0] src_a;
    logic [rv_core_pkg::XLEN-1:0] src_b;

    assign funct3 = fd_inst[rv_core_pkg::FUNCT3_LSB +: 3];
    assign funct7 = fd_inst[rv_core_pkg::FUNCT7_LSB +: 7];
    assign rs1    = fd_inst[rv_core_pkg::RS1_LSB +: rv_core_pkg::REG_ADDR_W];
    assign rs2    = fd_inst[rv_core_pkg::RS2_LSB +: rv_core_pkg::REG_ADDR_W];

    assign i_imm = {{20{fd_inst[31]}}, fd_inst[31:20]};
    assign u_imm = {fd_inst[31:12], 12'b0};
    assign b_imm = {{20{fd_inst[31]}}, fd_inst[7], fd_inst[30:25], fd_inst[11:8], 1'b0};

    // an empty slot decodes as a bubble
    always_comb begin
        kind = rv_core_pkg::KIND_NONE;
        if (fd_valid) begin
            case (fd_inst[6:0])
                rv_core_pkg::OPC_OP: begin
                    case ({funct7, funct3})
                        {7'h00, 3'b000}: kind = rv_core_pkg::KIND_ADD;
                        {7'h20, 3'b000}: kind = rv_core_pkg::KIND_SUB;
                        {7'h00, 3'b111}: kind = rv_core_pkg::KIND_AND;
                        {7'h00, 3'b110}: kind = rv_core_pkg::KIND_OR;
                        {7'h00, 3'b100}: kind = rv_core_pkg::KIND_XOR;
                        default:         kind = rv_core_pkg::KIND_NONE;
                    endcase
                end
                rv_core_pkg::OPC_OP_IMM: begin
                    if (funct3 == 3'b000) kind = rv_core_pkg::KIND_ADDI;
                end
                rv_core_pkg::OPC_LUI: kind = rv_core_pkg::KIND_LUI;
                rv_core_pkg::OPC_BRANCH: begin
                    if (funct3 == 3'b000) kind = rv_core_pkg::KIND_BEQ;
                    else if (funct3 == 3'b001) kind = rv_core_pkg::KIND_BNE;
                end
                rv_core_pkg::OPC_SYSTEM: begin
                    if (fd_inst == 32'h0010_0073) kind = rv_core_pkg::KIND_EBREAK;
                end
                default: kind = rv_core_pkg::KIND_NONE;
            endcase
        end
    end

    assign rs2_used = kind inside {rv_core_pkg::KIND_ADD, rv_core_pkg::KIND_SUB,
                                   rv_core_pkg::KIND_AND, rv_core_pkg::KIND_OR,
                                   rv_core_pkg::KIND_XOR, rv_core_pkg::KIND_BEQ,
                                   rv_core_pkg::KIND_BNE};
    assign rs1_used = rs2_used || (kind == rv_core_pkg::KIND_ADDI);

    // execute result is younger than writeback, so it is checked first
    assign src_a = (fwd_sel_a == rv_core_pkg::FWD_EX) ? ex_result :
                   (fwd_sel_a == rv_core_pkg::FWD_WB) ? wb_data : rs1_data;
    assign src_b = (fwd_sel_b == rv_core_pkg::FWD_EX) ? ex_result :
                   (fwd_sel_b == rv_core_pkg::FWD_WB) ? wb_data : rs2_data;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            de_valid <= 1'b0;
            de_kind  <= rv_core_pkg::KIND_NONE;
        end else begin
            de_valid <= !flush_de && (kind != rv_core_pkg::KIND_NONE);
            de_kind  <= flush_de ? rv_core_pkg::KIND_NONE : kind;
        end
    end

    // immediates replace operand b for ADDI and LUI
    always_ff @(posedge sys_clk) begin
        de_rd            <= fd_inst[rv_core_pkg::RD_LSB +: rv_core_pkg::REG_ADDR_W];
        de_pc            <= fd_pc;
        de_op_a          <= src_a;
        de_op_b          <= (kind == rv_core_pkg::KIND_ADDI) ? i_imm :
                            (kind == rv_core_pkg::KIND_LUI) ? u_imm : src_b;
        de_branch_target <= fd_pc + b_imm;
    end

endmodule

// File: hw/execute_stage.sv
module execute_stage (
    input  logic                               sys_clk,
    input  logic                               rst_n,
    input  logic                               de_valid,
    input  rv_core_pkg::inst_kind_e            de_kind,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] de_rd,
    input  logic [rv_core_pkg::XLEN-1:0]       de_op_a,
    input  logic [rv_core_pkg::XLEN-1:0]       de_op_b,
    input  logic [rv_core_pkg::XLEN-1:0]       de_branch_target,
    input  logic [rv_core_pkg::XLEN-1:0]       de_pc,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] ex_rd,
    output logic                               ex_wen,
    output logic [rv_core_pkg::XLEN-1:0]       ex_result,
    output logic                               branch_taken,
    output logic [rv_core_pkg::XLEN-1:0]       branch_target,
    output logic                               retire_valid,
    output logic [rv_core_pkg::XLEN-1:0]       retire_pc,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] retire_rd,
    output logic [rv_core_pkg::XLEN-1:0]       retire_data,
    output logic                               wb_wen,
    output logic                               ebreak
);

    logic is_alu;

    assign is_alu = de_kind inside {rv_core_pkg::KIND_ADD, rv_core_pkg::KIND_SUB,
                                    rv_core_pkg::KIND_AND, rv_core_pkg::KIND_OR,
                                    rv_core_pkg::KIND_XOR, rv_core_pkg::KIND_ADDI,
                                    rv_core_pkg::KIND_LUI};
    assign ex_rd  = de_rd;
    assign ex_wen = de_valid && is_alu;

    // branches and EBREAK fall to zero
    always_comb begin
        case (de_kind)
            rv_core_pkg::KIND_ADD,
            rv_core_pkg::KIND_ADDI: ex_result = de_op_a + de_op_b;
            rv_core_pkg::KIND_SUB:  ex_result = de_op_a - de_op_b;
            rv_core_pkg::KIND_AND:  ex_result = de_op_a & de_op_b;
            rv_core_pkg::KIND_OR:   ex_result = de_op_a | de_op_b;
            rv_core_pkg::KIND_XOR:  ex_result = de_op_a ^ de_op_b;
            rv_core_pkg::KIND_LUI:  ex_result = de_op_b;
            default:                ex_result = '0;
        endcase
    end

    assign branch_taken = de_valid &&
                          (((de_kind == rv_core_pkg::KIND_BEQ) && (de_op_a == de_op_b)) ||
                           ((de_kind == rv_core_pkg::KIND_BNE) && (de_op_a != de_op_b)));
    assign branch_target = de_branch_target;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            wb_wen       <= 1'b0;
            ebreak       <= 1'b0;
        end else begin
            retire_valid <= de_valid;
            // x0 still retires, it just never reaches the register file
            wb_wen       <= ex_wen && (de_rd != '0);
            ebreak       <= de_valid && (de_kind == rv_core_pkg::KIND_EBREAK);
        end
    end

    always_ff @(posedge sys_clk) begin
        retire_pc   <= de_pc;
        retire_rd   <= is_alu ? de_rd : '0;
        retire_data <= ex_result;
    end

    retire_known: assert property (@(posedge sys_clk) disable iff (!rst_n)
        !$isunknown({retire_valid, wb_wen, ebreak}))
        else $error("retire strobes unknown after reset");

endmodule

// File: hw/fetch_stage.sv
module fetch_stage #(
    parameter logic [rv_core_pkg::XLEN-1:0] RESET_ADDR = rv_core_pkg::RESET_PC
) (
    input  logic                         sys_clk,
    input  logic                         rst_n,
    input  logic                         branch_taken,
    input  logic [rv_core_pkg::XLEN-1:0] branch_target,
    input  logic                         flush_fd,
    output logic [rv_core_pkg::XLEN-1:0] inst_addr,
    input  logic [rv_core_pkg::XLEN-1:0] inst_data,
    output logic                         fd_valid,
    output logic [rv_core_pkg::XLEN-1:0] fd_pc,
    output logic [rv_core_pkg::XLEN-1:0] fd_inst
);

    logic [rv_core_pkg::XLEN-1:0] pc;

    assign inst_addr = pc;

    // redirect from execute wins over the sequential step
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_ADDR;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else begin
            pc <= pc + rv_core_pkg::XLEN'(4);
        end
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            fd_valid <= 1'b0;
        end else begin
            fd_valid <= !flush_fd;
        end
    end

    always_ff @(posedge sys_clk) begin
        fd_pc   <= pc;
        fd_inst <= inst_data;
    end

    // branch targets are built with bit 0 clear, so only a bad offset breaks this
    pc_aligned: assert property (@(posedge sys_clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("fetch pc misaligned: %h", pc);

endmodule

// File: hw/hazard_unit.sv
module hazard_unit (
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] rs1,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] rs2,
    input  logic                               rs1_used,
    input  logic                               rs2_used,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] ex_rd,
    input  logic                               ex_wen,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] retire_rd,
    input  logic                               wb_wen,
    input  logic                               branch_taken,
    output logic [1:0]                         fwd_sel_a,
    output logic [1:0]                         fwd_sel_b,
    output logic                               flush_fd,
    output logic                               flush_de
);

    // nearest producer wins
    function automatic logic [1:0] pick_src(
        input logic [rv_core_pkg::REG_ADDR_W-1:0] rs,
        input logic                               used
    );
        if (used && ex_wen && (ex_rd != '0) && (ex_rd == rs)) begin
            return rv_core_pkg::FWD_EX;
        end else if (used && wb_wen && (retire_rd != '0) && (retire_rd == rs)) begin
            return rv_core_pkg::FWD_WB;
        end
        return rv_core_pkg::FWD_RF;
    endfunction

    always_comb begin
        fwd_sel_a = pick_src(rs1, rs1_used);
        fwd_sel_b = pick_src(rs2, rs2_used);
    end

    // both younger slots hold wrong-path words
    assign flush_fd = branch_taken;
    assign flush_de = branch_taken;

endmodule

// File: hw/reg_file.sv
module reg_file (
    input  logic                               sys_clk,
    input  logic                               rst_n,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] rs1,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] rs2,
    output logic [rv_core_pkg::XLEN-1:0]       rs1_data,
    output logic [rv_core_pkg::XLEN-1:0]       rs2_data,
    input  logic                               wb_wen,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] retire_rd,
    input  logic [rv_core_pkg::XLEN-1:0]       retire_data
);

    logic [rv_core_pkg::XLEN-1:0] regs [rv_core_pkg::NUM_REGS];

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_core_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_wen && (retire_rd != '0)) begin
            regs[retire_rd] <= retire_data;
        end
    end

    // same-cycle write is covered by the writeback bypass
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

// File: hw/rv_core_pkg.sv
package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // decoded kinds, KIND_NONE covers bubbles and words outside the subset
    typedef enum logic [3:0] {
        KIND_NONE, KIND_ADD, KIND_SUB, KIND_AND, KIND_OR, KIND_XOR,
        KIND_ADDI, KIND_LUI, KIND_BEQ, KIND_BNE, KIND_EBREAK
    } inst_kind_e;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // field positions in the instruction word
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;

    // operand source select, hazard unit to decode
    localparam logic [1:0] FWD_RF = 2'd0;
    localparam logic [1:0] FWD_EX = 2'd1;
    localparam logic [1:0] FWD_WB = 2'd2;

endpackage

// File: hw/rv_core_top.sv
module rv_core_top #(
    parameter logic [rv_core_pkg::XLEN-1:0] RESET_ADDR = rv_core_pkg::RESET_PC
) (
    input  logic                               sys_clk,
    input  logic                               sys_rst_n,
    output logic [rv_core_pkg::XLEN-1:0]       inst_addr,
    input  logic [rv_core_pkg::XLEN-1:0]       inst_data,
    output logic                               retire_valid,
    output logic [rv_core_pkg::XLEN-1:0]       retire_pc,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] retire_rd,
    output logic [rv_core_pkg::XLEN-1:0]       retire_data,
    output logic                               ebreak
);

    logic rst_n_s1;
    logic rst_n_s2;
    logic rst_n;

    logic                               fd_valid;
    logic [rv_core_pkg::XLEN-1:0]       fd_pc;
    logic [rv_core_pkg::XLEN-1:0]       fd_inst;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rs2;
    logic                               rs1_used;
    logic                               rs2_used;
    logic [rv_core_pkg::XLEN-1:0]       rs1_data;
    logic [rv_core_pkg::XLEN-1:0]       rs2_data;
    logic [1:0]                         fwd_sel_a;
    logic [1:0]                         fwd_sel_b;
    logic                               de_valid;
    rv_core_pkg::inst_kind_e            de_kind;
    logic [rv_core_pkg::REG_ADDR_W-1:0] de_rd;
    logic [rv_core_pkg::XLEN-1:0]       de_op_a;
    logic [rv_core_pkg::XLEN-1:0]       de_op_b;
    logic [rv_core_pkg::XLEN-1:0]       de_branch_target;
    logic [rv_core_pkg::XLEN-1:0]       de_pc;
    logic [rv_core_pkg::REG_ADDR_W-1:0] ex_rd;
    logic                               ex_wen;
    logic [rv_core_pkg::XLEN-1:0]       ex_result;
    logic                               branch_taken;
    logic [rv_core_pkg::XLEN-1:0]       branch_target;
    logic                               wb_wen;
    logic                               flush_fd;
    logic                               flush_de;

    // asserted asynchronously, released on the second edge
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rst_n_s1 <= 1'b0;
            rst_n_s2 <= 1'b0;
        end else begin
            rst_n_s1 <= 1'b1;
            rst_n_s2 <= rst_n_s1;
        end
    end

    assign rst_n = rst_n_s2;

    fetch_stage #(.RESET_ADDR(RESET_ADDR)) u_fetch (.*);

    // writeback bypass comes straight off the retire register
    decode_stage u_decode (
        .ex_result (ex_result),
        .wb_data   (retire_data),
        .*
    );

    execute_stage u_execute (.*);

    reg_file u_reg_file (.*);

    hazard_unit u_hazard (.*);

endmodule

// File: include/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

typedef logic [31:0] word_q [$];

localparam logic [31:0] WORD_EBREAK = 32'h0010_0073;
localparam logic [31:0] WORD_NOP    = 32'h0000_0013;

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
        input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, rv_core_pkg::OPC_OP};
endfunction

function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
        input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, rv_core_pkg::OPC_OP_IMM};
endfunction

function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, rv_core_pkg::OPC_LUI};
endfunction

// off is the byte distance from the branch itself
function automatic logic [31:0] enc_br(input logic [2:0] f3, input logic [4:0] rs1,
        input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_core_pkg::OPC_BRANCH};
endfunction

// every ALU kind, then a write to x0 and a read of it
function automatic word_q prog_alu();
    return {enc_addi(1, 0, 12'd5), enc_addi(2, 0, 12'hffd), enc_lui(3, 20'h12345),
            enc_r(7'h00, 3'b000, 4, 1, 2), enc_r(7'h20, 3'b000, 5, 1, 2),
            enc_r(7'h00, 3'b111, 6, 3, 2), enc_r(7'h00, 3'b110, 7, 3, 1),
            enc_r(7'h00, 3'b100, 8, 7, 2), enc_addi(0, 1, 12'd9),
            enc_r(7'h00, 3'b000, 9, 0, 1), WORD_EBREAK};
endfunction

// producers at distance one and two
function automatic word_q prog_dep();
    return {enc_addi(1, 0, 12'd7), enc_r(7'h00, 3'b000, 2, 1, 1),
            enc_r(7'h20, 3'b000, 3, 2, 1), enc_r(7'h00, 3'b100, 4, 3, 2),
            enc_addi(5, 4, 12'h801), enc_r(7'h00, 3'b110, 6, 5, 4), WORD_EBREAK};
endfunction

// taken BEQ and BNE each skip two words, the other two fall through
function automatic word_q prog_branch();
    return {enc_addi(1, 0, 12'd3), enc_addi(2, 0, 12'd3), enc_br(3'b000, 1, 2, 13'd12),
            enc_addi(3, 0, 12'd1), enc_addi(3, 0, 12'd2), enc_br(3'b001, 1, 2, 13'd8),
            enc_addi(4, 0, 12'd4), enc_br(3'b001, 1, 0, 13'd12), enc_addi(5, 0, 12'd5),
            enc_addi(6, 0, 12'd6), enc_br(3'b000, 1, 0, 13'd8), enc_addi(7, 0, 12'd7),
            WORD_EBREAK};
endfunction

// one program-order step; retire rd/data come back, pc and regs move on
function automatic rv_core_pkg::inst_kind_e model_step(input logic [31:0] w,
        inout logic [31:0] pc, inout logic [31:0] regs [32],
        output logic [4:0] rd, output logic [31:0] data);
    rv_core_pkg::inst_kind_e kind;
    logic [31:0] a;
    logic [31:0] b;
    logic        taken;
    a    = regs[w[19:15]];
    b    = regs[w[24:20]];
    rd   = w[11:7];
    kind = rv_core_pkg::KIND_NONE;
    case (w[6:0])
        rv_core_pkg::OPC_OP: begin
            case ({w[30], w[14:12]})
                4'b0000: kind = rv_core_pkg::KIND_ADD;
                4'b1000: kind = rv_core_pkg::KIND_SUB;
                4'b0111: kind = rv_core_pkg::KIND_AND;
                4'b0110: kind = rv_core_pkg::KIND_OR;
                4'b0100: kind = rv_core_pkg::KIND_XOR;
                default: kind = rv_core_pkg::KIND_NONE;
            endcase
        end
        rv_core_pkg::OPC_OP_IMM: kind = rv_core_pkg::KIND_ADDI;
        rv_core_pkg::OPC_LUI:    kind = rv_core_pkg::KIND_LUI;
        rv_core_pkg::OPC_BRANCH: kind = w[12] ? rv_core_pkg::KIND_BNE : rv_core_pkg::KIND_BEQ;
        rv_core_pkg::OPC_SYSTEM: kind = rv_core_pkg::KIND_EBREAK;
        default:                 kind = rv_core_pkg::KIND_NONE;
    endcase
    case (kind)
        rv_core_pkg::KIND_ADD:  data = a + b;
        rv_core_pkg::KIND_SUB:  data = a - b;
        rv_core_pkg::KIND_AND:  data = a & b;
        rv_core_pkg::KIND_OR:   data = a | b;
        rv_core_pkg::KIND_XOR:  data = a ^ b;
        rv_core_pkg::KIND_ADDI: data = a + {{20{w[31]}}, w[31:20]};
        rv_core_pkg::KIND_LUI:  data = {w[31:12], 12'b0};
        default:                data = '0;
    endcase
    if (kind inside {rv_core_pkg::KIND_BEQ, rv_core_pkg::KIND_BNE, rv_core_pkg::KIND_EBREAK})
        rd = '0;
    taken = ((kind == rv_core_pkg::KIND_BEQ) && (a == b)) ||
            ((kind == rv_core_pkg::KIND_BNE) && (a != b));
    pc = taken ? pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0} : pc + 32'd4;
    if ((rd != '0) && (kind != rv_core_pkg::KIND_NONE))
        regs[rd] = data;
    return kind;
endfunction

`endif

// File: tests/rv_core_tb.sv
module rv_core_tb;

    `include "tb_programs.svh"

    localparam logic [31:0] RESET_ADDR = 32'h0000_0100;
    localparam logic [31:0] SEED       = 32'hd9daebfc;
    localparam int          IMEM_WORDS = 64;
    localparam int          RAND_LEN   = 40;

    logic        sys_clk;
    logic        sys_rst_n;
    logic [31:0] inst_addr;
    logic [31:0] inst_data;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;
    logic        ebreak;

    logic [31:0] imem [IMEM_WORDS];

    // expected retire stream, one entry per retirement
    logic [31:0] exp_pcs   [128];
    logic [4:0]  exp_rds   [128];
    logic [31:0] exp_datas [128];
    logic        exp_ebrs  [128];
    int          exp_count;
    logic [31:0] exp_pc;
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;
    logic        exp_ebr;

    logic [6:0]  retired_cnt;
    logic        checking;
    logic        test_done;
    logic        live;
    logic        reset_window;
    int          error_count;
    int          tests_failed;
    int          cycle_count;
    int          cycle_limit;
    word_q       p_alu;
    word_q       p_dep;
    word_q       p_branch;
    word_q       p_rand;

    rv_core_top #(.RESET_ADDR(RESET_ADDR)) dut0 (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .inst_addr    (inst_addr),
        .inst_data    (inst_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .ebreak       (ebreak)
    );

    initial sys_clk = 1'b0;
    always #50 sys_clk = ~sys_clk;

    // words past the loaded program read as a nop
    function automatic logic [31:0] imem_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - RESET_ADDR) >> 2;
        return (idx < IMEM_WORDS) ? imem[idx[5:0]] : WORD_NOP;
    endfunction

    always_comb inst_data = imem_word(inst_addr);

    assign exp_pc   = exp_pcs[retired_cnt];
    assign exp_rd   = exp_rds[retired_cnt];
    assign exp_data = exp_datas[retired_cnt];
    assign exp_ebr  = exp_ebrs[retired_cnt];
    assign live     = checking && !test_done;

    always @(posedge sys_clk) begin
        if (!checking) begin
            retired_cnt <= '0;
            test_done   <= 1'b0;
        end else if (retire_valid && !test_done) begin
            retired_cnt <= retired_cnt + 7'd1;
            test_done   <= ebreak;
        end
    end

    always @(posedge sys_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run passed its limit of %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
            input logic [31:0] want);
        $display("Error: %s is %h, expected %h", name, got, want);
        error_count++;
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        error_count++;
    endtask

    pc_check: assert property (@(posedge sys_clk) (live && retire_valid) |-> retire_pc == exp_pc)
        else report_mismatch("retire_pc", $sampled(retire_pc), $sampled(exp_pc));
    rd_check: assert property (@(posedge sys_clk) (live && retire_valid) |-> retire_rd == exp_rd)
        else report_mismatch("retire_rd", $sampled(retire_rd), $sampled(exp_rd));
    data_check: assert property (@(posedge sys_clk)
        (live && retire_valid) |-> retire_data == exp_data)
        else report_mismatch("retire_data", $sampled(retire_data), $sampled(exp_data));
    ebreak_check: assert property (@(posedge sys_clk) live |-> ebreak == (retire_valid && exp_ebr))
        else report_mismatch("ebreak", $sampled(ebreak), $sampled(retire_valid && exp_ebr));
    count_check: assert property (@(posedge sys_clk)
        (live && retire_valid) |-> retired_cnt < exp_count)
        else report_failure("a retirement arrived after the program should have ended");

    // reset and the two cycles after release
    quiet_retire: assert property (@(posedge sys_clk) reset_window |-> !retire_valid)
        else report_mismatch("retire_valid", $sampled(retire_valid), 0);
    quiet_ebreak: assert property (@(posedge sys_clk) reset_window |-> !ebreak)
        else report_mismatch("ebreak", $sampled(ebreak), 0);
    reset_addr: assert property (@(posedge sys_clk) reset_window |-> inst_addr == RESET_ADDR)
        else report_mismatch("inst_addr", $sampled(inst_addr), RESET_ADDR);

    task automatic load_program(input word_q prog);
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : WORD_NOP;
        end
    endtask

    // walks the program in order until EBREAK
    task automatic build_expected();
        logic [31:0]             regs [32];
        logic [31:0]             pc;
        logic [31:0]             pc_now;
        logic [4:0]              rd;
        logic [31:0]             data;
        rv_core_pkg::inst_kind_e kind;
        int                      steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc        = RESET_ADDR;
        exp_count = 0;
        steps     = 0;
        kind      = rv_core_pkg::KIND_NONE;
        while (kind != rv_core_pkg::KIND_EBREAK && exp_count < 128 && steps < 256) begin
            pc_now = pc;
            kind   = model_step(imem_word(pc), pc, regs, rd, data);
            if (kind != rv_core_pkg::KIND_NONE) begin
                exp_pcs[exp_count]   = pc_now;
                exp_rds[exp_count]   = rd;
                exp_datas[exp_count] = data;
                exp_ebrs[exp_count]  = (kind == rv_core_pkg::KIND_EBREAK);
                exp_count++;
            end
            steps++;
        end
    endtask

    task automatic apply_reset();
        sys_rst_n <= 1'b0;
        @(posedge sys_clk);
        reset_window <= 1'b1;
        checking     <= 1'b1;
        repeat (3) @(posedge sys_clk);
        sys_rst_n <= 1'b1;
        repeat (2) @(posedge sys_clk);
        reset_window <= 1'b0;
    endtask

    // branches only jump forward and never past the closing EBREAK
    function automatic word_q prog_random();
        word_q      p;
        int         op;
        int         span;
        logic [4:0] rd;
        logic [4:0] ra;
        logic [4:0] rb;
        for (int i = 0; i < RAND_LEN; i++) begin
            op = $urandom % 9;
            rd = $urandom % 8;
            ra = $urandom % 8;
            rb = $urandom % 8;
            case (op)
                0: p.push_back(enc_r(7'h00, 3'b000, rd, ra, rb));
                1: p.push_back(enc_r(7'h20, 3'b000, rd, ra, rb));
                2: p.push_back(enc_r(7'h00, 3'b111, rd, ra, rb));
                3: p.push_back(enc_r(7'h00, 3'b110, rd, ra, rb));
                4: p.push_back(enc_r(7'h00, 3'b100, rd, ra, rb));
                5: p.push_back(enc_addi(rd, ra, 12'($urandom)));
                6: p.push_back(enc_lui(rd, 20'($urandom)));
                default: begin
                    span = (RAND_LEN - i < 3) ? RAND_LEN - i : 3;
                    // equal sources now and then, so BEQ gets taken too
                    if ($urandom % 2) rb = ra;
                    p.push_back(enc_br((op == 7) ? 3'b000 : 3'b001, ra, rb,
                                       13'((1 + $urandom % span) * 4)));
                end
            endcase
        end
        p.push_back(WORD_EBREAK);
        return p;
    endfunction

    task automatic run_test(input string name, input word_q prog);
        int errs_before;
        int waited;
        errs_before = error_count;
        @(negedge sys_clk);
        load_program(prog);
        build_expected();
        @(posedge sys_clk);
        apply_reset();
        waited = 0;
        while (!test_done && waited < prog.size() * 4 + 20) begin
            @(posedge sys_clk);
            waited++;
        end
        checking <= 1'b0;
        if (!test_done) begin
            report_failure($sformatf("test %s: ebreak never pulsed", name));
        end
        if (error_count != errs_before) tests_failed++;
        $display("test %s: %0d of %0d retires seen, %0d errors", name, retired_cnt,
                 exp_count, error_count - errs_before);
    endtask

    initial begin
        sys_rst_n    = 1'b0;
        checking     = 1'b0;
        reset_window = 1'b0;
        error_count  = 0;
        tests_failed = 0;
        cycle_count  = 0;
        void'($urandom(SEED));
        p_alu       = prog_alu();
        p_dep       = prog_dep();
        p_branch    = prog_branch();
        p_rand      = prog_random();
        cycle_limit = (p_alu.size() + p_dep.size() + p_branch.size() + p_rand.size()) * 4 + 50;
        run_test("alu", p_alu);
        run_test("bypass", p_dep);
        run_test("branch", p_branch);
        run_test("random", p_rand);
        $display("summary: 4 tests, %0d failed, %0d errors", tests_failed, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
